// File: common/lcd_macros.svh
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// Panel geometry in pixels.
`define LCD_H_RES 16
`define LCD_V_RES 8

// Command and parameter words ahead of the pixel stream.
`define LCD_INIT_LEN 13
`define LCD_FRAME_WORDS (`LCD_INIT_LEN + `LCD_H_RES * `LCD_V_RES)

// Write strobe timing in pclk cycles.
`define LCD_WR_LOW 2
`define LCD_WR_HIGH 1

// Panel reset pulse length in pclk cycles.
`define LCD_RESET_WAIT 20

`endif

// File: common/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    typedef enum logic [1:0] {
        REF_IDLE,
        REF_ADDR,
        REF_DATA
    } lcd_refresh_state_e;

    typedef enum logic [2:0] {
        PANEL_RESET,
        WAIT_FRAME,
        FETCH,
        WRITE,
        FRAME_END
    } lcd_ctrl_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SETUP,
        WR_STROBE,
        WR_HOLD
    } lcd_writer_state_e;

    // Panel command set, sent with rs low.
    typedef enum logic [15:0] {
        SLPOUT = 16'h0011,
        COLMOD = 16'h003A,
        MADCTL = 16'h0036,
        CASET  = 16'h002A,
        RASET  = 16'h002B,
        DISPON = 16'h0029,
        RAMWR  = 16'h002C
    } lcd_cmd_e;

    typedef enum logic [1:0] {
        BG_SOLID,
        BG_BARS,
        BG_CHECKER,
        BG_GRADIENT
    } lcd_bg_e;

endpackage

`default_nettype wire

// File: hw/lcd_refresh.sv
`default_nettype none
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_refresh
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        enable,
    input  lcd_bg_e     bg_sel,
    input  logic [15:0] word_data,
    input  logic        word_rs,
    output logic [15:0] addr,
    output lcd_bg_e     frame_bg,
    output logic [15:0] refresh_data,
    output logic        refresh_rs,
    output logic        data_ok,
    output logic        refresh_ok
);

    lcd_refresh_state_e state;
    logic               last_word;

    assign last_word = (addr == 16'(`LCD_FRAME_WORDS - 1));

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state      <= REF_IDLE;
            addr       <= '0;
            frame_bg   <= BG_SOLID;
            data_ok    <= 1'b0;
            refresh_ok <= 1'b0;
        end else begin
            case (state)
                REF_IDLE: begin
                    if (enable) begin
                        state <= REF_ADDR;
                        if (addr == '0) begin
                            frame_bg <= bg_sel; // Held for the whole frame.
                        end
                    end
                end
                REF_ADDR: begin
                    state      <= REF_DATA;
                    data_ok    <= 1'b1;
                    refresh_ok <= last_word;
                end
                REF_DATA: begin
                    state      <= REF_IDLE;
                    data_ok    <= 1'b0;
                    refresh_ok <= 1'b0;
                    if (refresh_ok) begin
                        addr <= '0; // Wrap for the next frame.
                    end else begin
                        addr <= addr + 16'd1;
                    end
                end
                default: begin
                    state <= REF_IDLE;
                end
            endcase
        end
    end

    // Source word is valid in ADDR, one cycle after the address settled.
    always_ff @(posedge pclk) begin
        if (state == REF_ADDR) begin
            refresh_data <= word_data;
            refresh_rs   <= word_rs;
        end
    end

    a_data_ok_single: assert property (@(posedge pclk) disable iff (!rst_n)
        data_ok |=> !data_ok);

    a_refresh_ok_with_data: assert property (@(posedge pclk) disable iff (!rst_n)
        refresh_ok |-> data_ok);

endmodule

`default_nettype wire

// File: hw/lcd_frame_source.sv
`default_nettype none
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_frame_source
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic [15:0] addr,
    input  lcd_bg_e     frame_bg,
    output logic [15:0] word_data,
    output logic        word_rs
);

    logic [15:0] init_word;
    logic        init_rs;
    logic [15:0] pix;
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] pixel_word;

    always_comb begin
        init_rs = 1'b1;
        case (addr)
            16'd0:   begin init_word = SLPOUT; init_rs = 1'b0; end
            16'd1:   begin init_word = COLMOD; init_rs = 1'b0; end
            16'd2:   init_word = 16'h0055; // RGB565.
            16'd3:   begin init_word = MADCTL; init_rs = 1'b0; end
            16'd4:   init_word = 16'h0000;
            16'd5:   begin init_word = CASET; init_rs = 1'b0; end
            16'd6:   init_word = 16'h0000;
            16'd7:   init_word = 16'(`LCD_H_RES - 1);
            16'd8:   begin init_word = RASET; init_rs = 1'b0; end
            16'd9:   init_word = 16'h0000;
            16'd10:  init_word = 16'(`LCD_V_RES - 1);
            16'd11:  begin init_word = DISPON; init_rs = 1'b0; end
            default: begin init_word = RAMWR; init_rs = 1'b0; end
        endcase
    end

    assign pix = addr - 16'(`LCD_INIT_LEN);
    assign x   = pix % 16'(`LCD_H_RES);
    assign y   = pix / 16'(`LCD_H_RES);

    always_comb begin
        case (frame_bg)
            BG_SOLID:   pixel_word = 16'h001F;
            BG_BARS:    pixel_word = x[2] ? 16'hF800 : 16'h07E0;
            BG_CHECKER: pixel_word = (x[1] ^ y[1]) ? 16'hFFFF : 16'h0000;
            default:    pixel_word = x * 16'h0841; // Grey ramp across the row.
        endcase
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            word_data <= '0;
            word_rs   <= 1'b0;
        end else if (addr < 16'(`LCD_INIT_LEN)) begin
            word_data <= init_word;
            word_rs   <= init_rs;
        end else begin
            word_data <= pixel_word;
            word_rs   <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: lcd_ctrl/lcd_ctrl.sv
`default_nettype none
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_ctrl
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        frame_req,
    input  logic [15:0] refresh_data,
    input  logic        refresh_rs,
    input  logic        data_ok,
    input  logic        refresh_ok,
    input  logic        wr_done,
    output logic        enable,
    output logic        wr_start,
    output logic [15:0] wr_data,
    output logic        wr_rs,
    output logic        lcd_rst_n,
    output logic        frame_done
);

    localparam int RST_CNT_W = $clog2(`LCD_RESET_WAIT + 1);

    lcd_ctrl_state_e        state;
    logic [RST_CNT_W-1:0]   rst_cnt;
    logic                   last_word;

    assign enable     = (state == FETCH);
    assign lcd_rst_n  = (state != PANEL_RESET);
    assign frame_done = (state == FRAME_END);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= PANEL_RESET;
            rst_cnt   <= '0;
            wr_start  <= 1'b0;
            last_word <= 1'b0;
        end else begin
            wr_start <= 1'b0;
            case (state)
                PANEL_RESET: begin
                    if (rst_cnt == RST_CNT_W'(`LCD_RESET_WAIT - 1)) begin
                        state <= WAIT_FRAME;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                WAIT_FRAME: begin
                    if (frame_req) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (data_ok) begin
                        state     <= WRITE; // Drops enable before the next IDLE.
                        wr_start  <= 1'b1;
                        last_word <= refresh_ok;
                    end
                end
                WRITE: begin
                    if (wr_done) begin
                        state <= last_word ? FRAME_END : FETCH;
                    end
                end
                FRAME_END: begin
                    state <= WAIT_FRAME;
                end
                default: begin
                    state <= WAIT_FRAME;
                end
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state == FETCH && data_ok) begin
            wr_data <= refresh_data;
            wr_rs   <= refresh_rs;
        end
    end

    // No fetch is requested while the writer holds a word.
    a_no_fetch_in_write: assert property (@(posedge pclk) disable iff (!rst_n)
        data_ok |=> !enable && state == WRITE);

    a_no_word_in_write: assert property (@(posedge pclk) disable iff (!rst_n)
        (state == WRITE) |-> !data_ok);

endmodule

`default_nettype wire

// File: lcd_ctrl/lcd_bus_writer.sv
`default_nettype none
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_bus_writer
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        wr_start,
    input  logic [15:0] wr_data,
    input  logic        wr_rs,
    output logic        wr_done,
    output logic        lcd_cs_n,
    output logic        lcd_wr_n,
    output logic        lcd_rs,
    output logic [15:0] lcd_data
);

    lcd_writer_state_e state;
    logic [3:0]        cnt;

    assign lcd_cs_n = (state == WR_IDLE);
    assign lcd_wr_n = (state != WR_STROBE);
    assign wr_done  = (state == WR_HOLD) && (cnt == 4'(`LCD_WR_HIGH - 1));

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            cnt      <= '0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_start) begin
                        state    <= WR_SETUP;
                        lcd_rs   <= wr_rs;
                        lcd_data <= wr_data;
                    end
                end
                WR_SETUP: begin
                    state <= WR_STROBE;
                    cnt   <= '0;
                end
                WR_STROBE: begin
                    if (cnt == 4'(`LCD_WR_LOW - 1)) begin
                        state <= WR_HOLD; // Panel latches on this rising edge.
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                WR_HOLD: begin
                    if (cnt == 4'(`LCD_WR_HIGH - 1)) begin
                        state <= WR_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 4'd1;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    a_strobe_in_select: assert property (@(posedge pclk) disable iff (!rst_n)
        !lcd_wr_n |-> !lcd_cs_n && $past(!lcd_cs_n));

    a_strobe_width: assert property (@(posedge pclk) disable iff (!rst_n)
        $fell(lcd_wr_n) |-> !lcd_wr_n [*`LCD_WR_LOW] ##1 lcd_wr_n);

endmodule

`default_nettype wire

// File: hw/lcd_top.sv
`default_nettype none
`timescale 1ns/1ps

module lcd_top
    import lcd_pkg::*;
(
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        frame_req,
    input  lcd_bg_e     bg_sel,
    output logic        lcd_rst_n,
    output logic        lcd_cs_n,
    output logic        lcd_wr_n,
    output logic        lcd_rs,
    output logic [15:0] lcd_data,
    output logic        frame_done
);

    logic [15:0] addr;
    lcd_bg_e     frame_bg;
    logic [15:0] word_data;
    logic        word_rs;
    logic [15:0] refresh_data;
    logic        refresh_rs;
    logic        data_ok;
    logic        refresh_ok;
    logic        enable;
    logic        wr_start;
    logic [15:0] wr_data;
    logic        wr_rs;
    logic        wr_done;

    lcd_refresh u_refresh (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .enable       (enable),
        .bg_sel       (bg_sel),
        .word_data    (word_data),
        .word_rs      (word_rs),
        .addr         (addr),
        .frame_bg     (frame_bg),
        .refresh_data (refresh_data),
        .refresh_rs   (refresh_rs),
        .data_ok      (data_ok),
        .refresh_ok   (refresh_ok)
    );

    lcd_frame_source u_frame_source (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .addr      (addr),
        .frame_bg  (frame_bg),
        .word_data (word_data),
        .word_rs   (word_rs)
    );

    lcd_ctrl u_ctrl (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .frame_req    (frame_req),
        .refresh_data (refresh_data),
        .refresh_rs   (refresh_rs),
        .data_ok      (data_ok),
        .refresh_ok   (refresh_ok),
        .wr_done      (wr_done),
        .enable       (enable),
        .wr_start     (wr_start),
        .wr_data      (wr_data),
        .wr_rs        (wr_rs),
        .lcd_rst_n    (lcd_rst_n),
        .frame_done   (frame_done)
    );

    lcd_bus_writer u_bus_writer (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .wr_start (wr_start),
        .wr_data  (wr_data),
        .wr_rs    (wr_rs),
        .wr_done  (wr_done),
        .lcd_cs_n (lcd_cs_n),
        .lcd_wr_n (lcd_wr_n),
        .lcd_rs   (lcd_rs),
        .lcd_data (lcd_data)
    );

endmodule

`default_nettype wire

// File: tb/lcd_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "lcd_macros.svh"

module lcd_tb
    import lcd_pkg::*;
;

    localparam int NUM_FRAMES  = 8;
    localparam int CYCLE_LIMIT = NUM_FRAMES * `LCD_FRAME_WORDS * 10 + `LCD_RESET_WAIT + 2000;

    logic    pclk;
    logic    rst_n;
    logic    frame_req;
    lcd_bg_e bg_sel;
    logic    lcd_rst_n;
    logic    lcd_cs_n;
    logic    lcd_wr_n;
    logic    lcd_rs;
    logic [15:0] lcd_data;
    logic    frame_done;

    lcd_bg_e frame_bg_exp = BG_SOLID; // Background the current frame was started with.
    int      words_seen   = 0;
    int      done_count   = 0;
    int      low_run      = 0;
    int      cycle_count  = 0;
    int      fail_count   = 0;
    logic    bus_quiet    = 1'b1;
    logic    wr_n_prev    = 1'b1;

    lcd_top dut_i (
        .pclk       (pclk),
        .rst_n      (rst_n),
        .frame_req  (frame_req),
        .bg_sel     (bg_sel),
        .lcd_rst_n  (lcd_rst_n),
        .lcd_cs_n   (lcd_cs_n),
        .lcd_wr_n   (lcd_wr_n),
        .lcd_rs     (lcd_rs),
        .lcd_data   (lcd_data),
        .frame_done (frame_done)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_count++;
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // Reference word as {rs, data} for a word index within the frame.
    function automatic logic [16:0] expected_word(input int idx, input lcd_bg_e bg);
        int          x;
        int          y;
        logic [31:0] grad;
        logic [16:0] w;
        if (idx < `LCD_INIT_LEN) begin
            case (idx)
                0:       w = {1'b0, 16'h0011};
                1:       w = {1'b0, 16'h003A};
                2:       w = {1'b1, 16'h0055};
                3:       w = {1'b0, 16'h0036};
                4:       w = {1'b1, 16'h0000};
                5:       w = {1'b0, 16'h002A};
                6:       w = {1'b1, 16'h0000};
                7:       w = {1'b1, 16'(`LCD_H_RES - 1)};
                8:       w = {1'b0, 16'h002B};
                9:       w = {1'b1, 16'h0000};
                10:      w = {1'b1, 16'(`LCD_V_RES - 1)};
                11:      w = {1'b0, 16'h0029};
                default: w = {1'b0, 16'h002C};
            endcase
        end else begin
            x    = (idx - `LCD_INIT_LEN) % `LCD_H_RES;
            y    = (idx - `LCD_INIT_LEN) / `LCD_H_RES;
            grad = x * 32'h0841;
            case (bg)
                BG_SOLID:   w = {1'b1, 16'h001F};
                BG_BARS:    w = {1'b1, (x[2] ? 16'hF800 : 16'h07E0)};
                BG_CHECKER: w = {1'b1, ((x[1] ^ y[1]) ? 16'hFFFF : 16'h0000)};
                default:    w = {1'b1, grad[15:0]};
            endcase
        end
        return w;
    endfunction

    // Bus monitor, samples between clock edges.
    always @(negedge pclk) begin
        if (rst_n) begin
            if (bus_quiet && (!lcd_cs_n || !lcd_wr_n)) begin
                abort_run("bus activity seen while frame_req was low");
            end else begin
                if (frame_done) begin
                    check_equal(words_seen, `LCD_FRAME_WORDS, "writes before frame_done");
                    words_seen = 0; // Next frame starts at word 0.
                    done_count++;
                end
                if (!lcd_wr_n) begin
                    low_run++;
                    check_equal(lcd_cs_n, 1'b0, "chip select during strobe");
                end else if (!wr_n_prev) begin
                    check_equal(low_run, `LCD_WR_LOW, "strobe low width");
                    check_equal(lcd_cs_n, 1'b0, "chip select at strobe rise");
                    if (words_seen >= `LCD_FRAME_WORDS) begin
                        abort_run("more writes in a frame than the frame has words");
                    end else begin
                        check_equal({15'b0, lcd_rs, lcd_data},
                                    {15'b0, expected_word(words_seen, frame_bg_exp)},
                                    $sformatf("word %0d rs and data", words_seen));
                        words_seen++;
                    end
                    low_run = 0;
                end
                wr_n_prev = lcd_wr_n;
            end
        end
    end

    always @(posedge pclk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, no end of test after %0d cycles", cycle_count));
        end
    end

    // Runs one frame, optionally switching bg_sel partway through it.
    task automatic run_frame(input lcd_bg_e bg, input bit change_mid, input lcd_bg_e new_bg,
                             input int gap);
        int start_done;
        int change_at;
        start_done   = done_count;
        change_at    = 40 + ($urandom % 60);
        frame_bg_exp = bg;
        bg_sel       = bg;
        bus_quiet    = 1'b0;
        frame_req    = 1'b1;
        while (done_count == start_done) begin
            @(posedge pclk);
            #2;
            if (change_mid && words_seen >= change_at) begin
                bg_sel = new_bg;
            end
        end
        if (gap > 0) begin
            frame_req = 1'b0;
            bus_quiet = 1'b1; // Gap must stay silent.
            repeat (gap) @(posedge pclk);
            #2;
            check_equal(done_count - start_done, 1, "frame_done pulses after gap");
        end
    endtask

    initial begin
        lcd_bg_e bg_a;
        lcd_bg_e bg_b;
        int      rst_low;
        void'($urandom(32'hbf99f054));
        rst_n     = 1'b0;
        frame_req = 1'b0;
        bg_sel    = BG_SOLID;
        repeat (2) @(posedge pclk);
        #2;
        rst_n = 1'b1;
        check_equal(lcd_cs_n, 1'b1, "cs_n after reset");
        check_equal(lcd_wr_n, 1'b1, "wr_n after reset");
        check_equal(frame_done, 1'b0, "frame_done after reset");
        check_equal(lcd_data, 16'h0000, "lcd_data after reset");
        rst_low = 0;
        while (!lcd_rst_n && rst_low < 100) begin
            rst_low++;
            @(posedge pclk);
            #2;
        end
        check_equal(rst_low, `LCD_RESET_WAIT, "panel reset length");
        repeat (30) @(posedge pclk);
        #2;
        check_equal(lcd_rst_n, 1'b1, "panel reset released");
        check_equal(done_count, 0, "frame_done while idle");

        run_frame(BG_SOLID, 1'b0, BG_SOLID, $urandom % 25);
        run_frame(BG_BARS, 1'b0, BG_BARS, $urandom % 25);
        run_frame(BG_CHECKER, 1'b0, BG_CHECKER, $urandom % 25);
        run_frame(BG_GRADIENT, 1'b0, BG_GRADIENT, $urandom % 25);

        bg_a = lcd_bg_e'($urandom % 4);
        bg_b = lcd_bg_e'(bg_a + 2'd1);
        run_frame(bg_a, 1'b1, bg_b, $urandom % 25);
        run_frame(bg_b, 1'b0, bg_b, $urandom % 25);

        run_frame(lcd_bg_e'($urandom % 4), 1'b0, BG_SOLID, 0); // Back to back.
        run_frame(lcd_bg_e'($urandom % 4), 1'b0, BG_SOLID, 5 + $urandom % 20);

        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            abort_run("checks reported mismatches");
        end
    end

endmodule

`default_nettype wire

// File: lcd_top.f
+incdir+common
common/lcd_pkg.sv
hw/lcd_refresh.sv
hw/lcd_frame_source.sv
lcd_ctrl/lcd_ctrl.sv
lcd_ctrl/lcd_bus_writer.sv
hw/lcd_top.sv
tb/lcd_tb.sv

// File: Bender.yml
package:
  name: lcd_top

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lcd_pkg.sv
      - hw/lcd_refresh.sv
      - hw/lcd_frame_source.sv
      - lcd_ctrl/lcd_ctrl.sv
      - lcd_ctrl/lcd_bus_writer.sv
      - hw/lcd_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/lcd_tb.sv
